/* hw/dbg_key_pulse.sv */
// Push key pulse generator
`default_nettype none

module dbg_key_pulse (
    input  wire logic       i_clk,
    input  wire logic       i_arst_n,

    input  wire logic [1:0] i_key_n,      // Raw keys, active low.
    output logic      [1:0] o_key_pulse
);

    logic [1:0] key;
    logic [1:0] sync_meta;
    logic [1:0] sync_q;
    logic [1:0] level_q;

    assign key = ~i_key_n;  // Pressed reads as one.

    // ========================================================================
    // Two-stage synchronizer
    // ========================================================================

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            sync_meta <= key;
            sync_q    <= sync_meta;
        end
    end

    // ========================================================================
    // Edge detector
    // ========================================================================

    // Previous synchronized level.
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            level_q <= '0;
        end else begin
            level_q <= sync_q;
        end
    end

    // High for one cycle after the synchronized key rises.
    assign o_key_pulse = sync_q & ~level_q;

endmodule

`default_nettype wire

/* hw/dbg_pkg.sv */
// Debug monitor definitions
`default_nettype none

package dbg_pkg;

    // ========================================================================
    // Widths
    // ========================================================================

    localparam int DATA_WIDTH = 32;  // Retire data and test port.
    localparam int ADDR_WIDTH = 32;  // Redirect address.
    localparam int RDST_WIDTH = 5;   // Architectural register index.

    // ========================================================================
    // Seven-segment display
    // ========================================================================

    localparam int NUM_DIGITS = 8;
    localparam int SEG_WIDTH  = 7;

    // Segments are active low, so all ones is a dark digit.
    localparam logic [SEG_WIDTH-1:0] SEG_BLANK = 7'b111_1111;

    // ========================================================================
    // Test port codes and monitor states
    // ========================================================================

    localparam logic [DATA_WIDTH-1:0] TEST_PASS_CODE = 32'h0000_4a33;
    localparam logic [DATA_WIDTH-1:0] TEST_FAIL_CODE = 32'h0000_fae1;

    // Bit 1 set means the core is stopped.
    typedef enum logic [1:0] {
        DBG_RUN  = 2'b00,
        DBG_STEP = 2'b01,
        DBG_HALT = 2'b10,
        DBG_DONE = 2'b11
    } dbg_state_t;

endpackage

`default_nettype wire

/* hw/dbg_retire_capture.sv */
// Retire report capture
`default_nettype none

module dbg_retire_capture import dbg_pkg::*; (
    input  wire logic                  i_clk,
    input  wire logic                  i_arst_n,

    input  wire logic                  i_capture_en,
    input  wire logic                  i_done_en,

    input  wire logic [RDST_WIDTH-1:0] i_retire_rdst,
    input  wire logic [DATA_WIDTH-1:0] i_retire_data,
    input  wire logic                  i_redirect,
    input  wire logic [ADDR_WIDTH-1:0] i_redirect_addr,
    input  wire logic [DATA_WIDTH-1:0] i_sim_tp,

    output logic      [RDST_WIDTH-1:0] o_rdst_q,
    output logic      [DATA_WIDTH-1:0] o_data_q,
    output logic                       o_redirect_q,
    output logic      [ADDR_WIDTH-1:0] o_redirect_addr_q
);

    logic [DATA_WIDTH-1:0] data_next;
    logic                  data_en;

    // Once done the digits track the test port instead of the retire data.
    assign data_next = i_done_en ? i_sim_tp : i_retire_data;
    assign data_en   = i_capture_en | i_done_en;

    // ========================================================================
    // Retire report registers
    // ========================================================================

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_rdst_q          <= '0;
            o_redirect_q      <= 1'b0;
            o_redirect_addr_q <= '0;
        end else if (i_capture_en) begin
            o_rdst_q          <= i_retire_rdst;
            o_redirect_q      <= i_redirect;
            o_redirect_addr_q <= i_redirect_addr;
        end
    end

    // ========================================================================
    // Data register
    // ========================================================================

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_data_q <= '0;
        end else if (data_en) begin
            o_data_q <= data_next;
        end
    end

endmodule

`default_nettype wire

/* hw/dbg_seg7_display.sv */
// Board display driver
`default_nettype none

module dbg_seg7_display import dbg_pkg::*; (
    input  wire logic                  i_clk,
    input  wire logic                  i_arst_n,

    input  wire logic [DATA_WIDTH-1:0] i_data_q,
    input  wire logic [RDST_WIDTH-1:0] i_rdst_q,
    input  wire logic                  i_redirect_q,
    input  wire logic [ADDR_WIDTH-1:0] i_redirect_addr_q,
    input  wire logic                  i_core_run,

    output logic [NUM_DIGITS-1:0][SEG_WIDTH-1:0] o_hex,
    output logic [17:0]                          o_ledr,
    output logic [RDST_WIDTH-1:0]                o_ledg
);

    logic [NUM_DIGITS-1:0][SEG_WIDTH-1:0] hex_next;

    // Active low, bit order gfedcba.
    function automatic logic [SEG_WIDTH-1:0] seg7_decode(input logic [3:0] nibble);
        case (nibble)
            4'h0: seg7_decode = 7'b100_0000;
            4'h1: seg7_decode = 7'b111_1001;
            4'h2: seg7_decode = 7'b010_0100;
            4'h3: seg7_decode = 7'b011_0000;
            4'h4: seg7_decode = 7'b001_1001;
            4'h5: seg7_decode = 7'b001_0010;
            4'h6: seg7_decode = 7'b000_0010;
            4'h7: seg7_decode = 7'b111_1000;
            4'h8: seg7_decode = 7'b000_0000;
            4'h9: seg7_decode = 7'b001_0000;
            4'ha: seg7_decode = 7'b000_1000;
            4'hb: seg7_decode = 7'b000_0011;
            4'hc: seg7_decode = 7'b100_0110;
            4'hd: seg7_decode = 7'b010_0001;
            4'he: seg7_decode = 7'b000_0110;
            default: seg7_decode = 7'b000_1110;
        endcase
    endfunction

    always_comb begin
        for (int k = 0; k < NUM_DIGITS; k++) begin
            hex_next[k] = seg7_decode(i_data_q[k*4 +: 4]);
        end
    end

    // All board outputs registered together.
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_hex  <= {NUM_DIGITS{SEG_BLANK}};
            o_ledr <= '0;
            o_ledg <= '0;
        end else begin
            o_hex  <= hex_next;
            o_ledr <= {i_core_run, i_redirect_q, i_redirect_addr_q[15:0]};
            o_ledg <= i_rdst_q;
        end
    end

endmodule

`default_nettype wire

/* hw/dbg_step_ctrl.sv */
// Run and step control
`default_nettype none

module dbg_step_ctrl import dbg_pkg::*; (
    input  wire logic                  i_clk,
    input  wire logic                  i_arst_n,

    input  wire logic [1:0]            i_key_pulse,  // 1 run/step, 0 step once.
    input  wire logic                  i_retire_en,
    input  wire logic [DATA_WIDTH-1:0] i_sim_tp,

    output dbg_state_t                 o_state,
    output logic                       o_capture_en,
    output logic                       o_done_en,
    output logic                       o_core_run
);

    dbg_state_t state_q;
    dbg_state_t state_next;
    logic       test_finished;

    assign test_finished = (i_sim_tp == TEST_PASS_CODE) || (i_sim_tp == TEST_FAIL_CODE);

    // ========================================================================
    // Next state
    // ========================================================================

    always_comb begin
        state_next = state_q;

        unique case (state_q)
            DBG_RUN: begin
                if (test_finished) begin
                    state_next = DBG_DONE;  // End-of-test code wins.
                end else if (i_key_pulse[1]) begin
                    state_next = DBG_STEP;
                end
            end
            DBG_STEP: begin
                if (i_retire_en) begin
                    state_next = DBG_HALT;  // Exactly one retire.
                end
            end
            DBG_HALT, DBG_DONE: begin
                if (i_key_pulse[1]) begin
                    state_next = DBG_RUN;
                end else if (i_key_pulse[0]) begin
                    state_next = DBG_STEP;
                end
            end
            default: state_next = DBG_RUN;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= DBG_RUN;
        end else begin
            state_q <= state_next;
        end
    end

    // ========================================================================
    // Outputs
    // ========================================================================

    assign o_state      = state_q;
    assign o_capture_en = i_retire_en && (state_q == DBG_STEP);
    assign o_done_en    = (state_q == DBG_DONE);
    assign o_core_run   = ~state_q[1];  // RUN and STEP.

endmodule

`default_nettype wire

/* hw/dbg_sys_top.sv */
// Debug monitor top level
`default_nettype none

module dbg_sys_top import dbg_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  i_arst_n,

    input  wire logic [1:0]            i_key_n,

    // Core retire, redirect and test port.
    input  wire logic                  i_retire_en,
    input  wire logic [RDST_WIDTH-1:0] i_retire_rdst,
    input  wire logic [DATA_WIDTH-1:0] i_retire_data,
    input  wire logic                  i_redirect,
    input  wire logic [ADDR_WIDTH-1:0] i_redirect_addr,
    input  wire logic [DATA_WIDTH-1:0] i_sim_tp,

    output logic                                 o_core_run,  // Core clock enable.
    output logic [17:0]                          o_ledr,
    output logic [RDST_WIDTH-1:0]                o_ledg,
    output logic [NUM_DIGITS-1:0][SEG_WIDTH-1:0] o_hex
);

    logic [1:0]            key_pulse;
    logic                  capture_en;
    logic                  done_en;
    logic                  core_run;
    logic [RDST_WIDTH-1:0] rdst_q;
    logic [DATA_WIDTH-1:0] data_q;
    logic                  redirect_q;
    logic [ADDR_WIDTH-1:0] redirect_addr_q;

    // ========================================================================
    // Keys and control
    // ========================================================================

    dbg_key_pulse dbg_key_pulse_inst (
        .i_clk       (clk),
        .i_arst_n    (i_arst_n),
        .i_key_n     (i_key_n),
        .o_key_pulse (key_pulse)
    );

    dbg_step_ctrl dbg_step_ctrl_inst (
        .i_clk        (clk),
        .i_arst_n     (i_arst_n),
        .i_key_pulse  (key_pulse),
        .i_retire_en  (i_retire_en),
        .i_sim_tp     (i_sim_tp),
        .o_state      (),
        .o_capture_en (capture_en),
        .o_done_en    (done_en),
        .o_core_run   (core_run)
    );

    assign o_core_run = core_run;

    // ========================================================================
    // Capture and display
    // ========================================================================

    dbg_retire_capture dbg_retire_capture_inst (
        .i_clk             (clk),
        .i_arst_n          (i_arst_n),
        .i_capture_en      (capture_en),
        .i_done_en         (done_en),
        .i_retire_rdst     (i_retire_rdst),
        .i_retire_data     (i_retire_data),
        .i_redirect        (i_redirect),
        .i_redirect_addr   (i_redirect_addr),
        .i_sim_tp          (i_sim_tp),
        .o_rdst_q          (rdst_q),
        .o_data_q          (data_q),
        .o_redirect_q      (redirect_q),
        .o_redirect_addr_q (redirect_addr_q)
    );

    dbg_seg7_display dbg_seg7_display_inst (
        .i_clk             (clk),
        .i_arst_n          (i_arst_n),
        .i_data_q          (data_q),
        .i_rdst_q          (rdst_q),
        .i_redirect_q      (redirect_q),
        .i_redirect_addr_q (redirect_addr_q),
        .i_core_run        (core_run),
        .o_hex             (o_hex),
        .o_ledr            (o_ledr),
        .o_ledg            (o_ledg)
    );

endmodule

`default_nettype wire

/* test/dbg_sys_top_chk.sv */
// Control block assertions
`default_nettype none

module dbg_sys_top_chk import dbg_pkg::*; (
    input wire logic                  i_clk,
    input wire logic                  i_arst_n,
    input wire dbg_state_t            i_state,
    input wire logic                  i_retire_en,
    input wire logic [DATA_WIDTH-1:0] i_sim_tp,
    input wire logic                  i_capture_en,
    input wire logic                  i_core_run
);

    timeunit 1ns;
    timeprecision 1ps;

    int run_fails     = 0;
    int halt_fails    = 0;
    int done_fails    = 0;
    int capture_fails = 0;
    int fail_count;

    assign fail_count = run_fails + halt_fails + done_fails + capture_fails;

    a_core_run: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_core_run == (i_state == DBG_RUN || i_state == DBG_STEP))
        else begin
            $error("core run enable does not match the state");
            run_fails++;
        end

    // HALT is reached only by a retire in STEP.
    a_halt_entry: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_state == DBG_HALT && $past(i_state) != DBG_HALT)
            |-> $past(i_state == DBG_STEP && i_retire_en))
        else begin
            $error("HALT entered without a retire in STEP");
            halt_fails++;
        end

    a_done_entry: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_state == DBG_DONE && $past(i_state) != DBG_DONE)
            |-> $past(i_state == DBG_RUN &&
                      (i_sim_tp == TEST_PASS_CODE || i_sim_tp == TEST_FAIL_CODE)))
        else begin
            $error("DONE entered without a test code in RUN");
            done_fails++;
        end

    a_capture_step: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_capture_en |-> (i_state == DBG_STEP))
        else begin
            $error("capture enable high outside STEP");
            capture_fails++;
        end

endmodule

`default_nettype wire

/* test/tb_clk_gen.sv */
// Testbench clock and reset
`default_nettype none

module tb_clk_gen (
    output logic o_clk,
    output logic o_arst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam time HALF_PERIOD  = 20ns;  // 40 ns clock.
    localparam int  RESET_CYCLES = 2;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // Release on a falling edge, away from the capture edge.
    initial begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* test/tb_dbg_sys_top.sv */
// Debug monitor testbench
`default_nettype none

module tb_dbg_sys_top import dbg_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 2000;

    logic clk, arst_n;
    logic [1:0] key_n;
    logic retire_en, redirect;
    logic [RDST_WIDTH-1:0] retire_rdst;
    logic [DATA_WIDTH-1:0] retire_data, sim_tp;
    logic [ADDR_WIDTH-1:0] redirect_addr;
    logic core_run;
    logic [17:0] ledr;
    logic [RDST_WIDTH-1:0] ledg;
    logic [NUM_DIGITS-1:0][SEG_WIDTH-1:0] hex;

    // Reference model.
    dbg_state_t exp_state;
    logic [RDST_WIDTH-1:0] exp_rdst;
    logic [DATA_WIDTH-1:0] exp_data;
    logic exp_redirect;
    logic [ADDR_WIDTH-1:0] exp_addr;

    string current_test;
    int checks_failed = 0;
    int test_start_fails;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    int assert_fails;

    tb_clk_gen clk_gen_inst (.o_clk(clk), .o_arst_n(arst_n));

    dbg_sys_top dbg_sys_top_inst (
        .clk(clk), .i_arst_n(arst_n), .i_key_n(key_n),
        .i_retire_en(retire_en), .i_retire_rdst(retire_rdst), .i_retire_data(retire_data),
        .i_redirect(redirect), .i_redirect_addr(redirect_addr), .i_sim_tp(sim_tp),
        .o_core_run(core_run), .o_ledr(ledr), .o_ledg(ledg), .o_hex(hex)
    );

    bind dbg_step_ctrl dbg_sys_top_chk dbg_sys_top_chk_inst (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_state(o_state), .i_retire_en(i_retire_en),
        .i_sim_tp(i_sim_tp), .i_capture_en(o_capture_en), .i_core_run(o_core_run)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ========================================================================
    // Model helpers
    // ========================================================================

    function automatic logic [SEG_WIDTH-1:0] seg_pattern(input logic [3:0] nibble);
        logic [6:0] lit;  // Lit segments, gfedcba.
        case (nibble)
            4'h0: lit = 7'h3f;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5b;
            4'h3: lit = 7'h4f;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6d;
            4'h6: lit = 7'h7d;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7f;
            4'h9: lit = 7'h6f;
            4'ha: lit = 7'h77;
            4'hb: lit = 7'h7c;
            4'hc: lit = 7'h39;
            4'hd: lit = 7'h5e;
            4'he: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    function automatic logic [NUM_DIGITS-1:0][SEG_WIDTH-1:0] expected_hex(
        input logic [DATA_WIDTH-1:0] value
    );
        logic [NUM_DIGITS-1:0][SEG_WIDTH-1:0] digits;
        for (int k = 0; k < NUM_DIGITS; k++) begin
            digits[k] = seg_pattern(value[k*4 +: 4]);
        end
        return digits;
    endfunction

    // A test code ends RUN, and DONE keeps copying the test port.
    task automatic apply_test_port();
        if (exp_state == DBG_RUN && (sim_tp == TEST_PASS_CODE || sim_tp == TEST_FAIL_CODE)) begin
            exp_state = DBG_DONE;
        end
        if (exp_state == DBG_DONE) begin
            exp_data = sim_tp;
        end
    endtask

    task automatic check_value(input string sig, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s expected %h actual %h", current_test, sig, expected, actual);
            checks_failed++;
        end
    endtask

    task automatic check_outputs();
        logic run;
        run = (exp_state == DBG_RUN) || (exp_state == DBG_STEP);
        check_value("o_core_run", run, core_run);
        check_value("o_ledg", exp_rdst, ledg);
        check_value("o_ledr", {run, exp_redirect, exp_addr[15:0]}, ledr);
        check_value("o_hex", expected_hex(exp_data), hex);
    endtask

    // ========================================================================
    // Stimulus tasks, entered and left on a falling edge
    // ========================================================================

    task automatic settle_outputs();
        retire_en = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    task automatic press_key(input int key);
        key_n[key] = 1'b0;
        repeat (6) @(negedge clk);
        key_n[key] = 1'b1;
        repeat (6) @(negedge clk);
        if (key == 1 && exp_state == DBG_RUN) begin
            exp_state = DBG_STEP;
        end else if (exp_state == DBG_HALT || exp_state == DBG_DONE) begin
            exp_state = (key == 1) ? DBG_RUN : DBG_STEP;
        end
        apply_test_port();
    endtask

    task automatic retire_cycle(input logic en);
        retire_en     = en;
        retire_rdst   = RDST_WIDTH'($urandom);
        retire_data   = $urandom;
        redirect      = 1'($urandom);
        redirect_addr = $urandom;
        if (en && exp_state == DBG_STEP) begin
            exp_rdst     = retire_rdst;
            exp_data     = retire_data;
            exp_redirect = redirect;
            exp_addr     = redirect_addr;
            exp_state    = DBG_HALT;
        end
        @(negedge clk);
    endtask

    task automatic drive_tp(input logic [DATA_WIDTH-1:0] value);
        sim_tp = value;
        apply_test_port();
        @(negedge clk);
    endtask

    task automatic start_test(input string name);
        current_test     = name;
        test_start_fails = checks_failed;
    endtask

    task automatic end_test();
        tests_run++;
        if (checks_failed == test_start_fails) begin
            $display("test %s: passed", current_test);
        end else begin
            $display("test %s: failed, %0d errors", current_test, checks_failed - test_start_fails);
            tests_failed++;
        end
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================

    task automatic test_reset();
        start_test("reset");
        @(posedge clk);
        @(negedge clk);
        check_value("o_hex in reset", {NUM_DIGITS{SEG_BLANK}}, hex);
        wait (arst_n === 1'b1);
        @(negedge clk);
        settle_outputs();
        check_outputs();
        end_test();
    endtask

    task automatic test_single_step();
        start_test("single_step");
        press_key(1);
        check_outputs();
        retire_cycle(1'b1);
        check_value("o_core_run after retire", 1'b0, core_run);
        retire_cycle(1'b1);
        check_value("o_hex after retire", expected_hex(exp_data), hex);
        for (int i = 0; i < 6; i++) begin
            retire_cycle(1'($urandom));
        end
        settle_outputs();
        check_outputs();
        end_test();
    endtask

    task automatic test_halt_holds();
        start_test("halt_holds");
        for (int i = 0; i < 5; i++) begin
            retire_cycle(1'b1);
        end
        settle_outputs();
        check_outputs();
        press_key(0);
        check_outputs();
        retire_cycle(1'b1);
        settle_outputs();
        check_outputs();
        end_test();
    endtask

    task automatic test_resume();
        start_test("resume");
        press_key(1);
        check_outputs();
        for (int i = 0; i < 5; i++) begin
            retire_cycle(1'b1);
        end
        settle_outputs();
        check_outputs();
        end_test();
    endtask

    task automatic test_test_end();
        start_test("test_end");
        drive_tp(TEST_PASS_CODE);
        settle_outputs();
        check_outputs();
        drive_tp('0);
        press_key(1);
        settle_outputs();
        check_outputs();
        drive_tp(TEST_FAIL_CODE);
        settle_outputs();
        check_outputs();
        end_test();
    endtask

    initial begin
        key_n         = 2'b11;
        retire_en     = 1'b0;
        retire_rdst   = '0;
        retire_data   = '0;
        redirect      = 1'b0;
        redirect_addr = '0;
        sim_tp        = '0;
        exp_state     = DBG_RUN;
        exp_rdst      = '0;
        exp_data      = '0;
        exp_redirect  = 1'b0;
        exp_addr      = '0;
        void'($urandom(32'h877f2e51));

        test_reset();
        test_single_step();
        test_halt_holds();
        test_resume();
        test_test_end();

        assert_fails = dbg_sys_top_inst.dbg_step_ctrl_inst.dbg_sys_top_chk_inst.fail_count;
        $display("tests run %0d, tests failed %0d, checks failed %0d, assertion failures %0d",
                 tests_run, tests_failed, checks_failed, assert_fails);
        if (checks_failed == 0 && tests_failed == 0 && assert_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/dbg_pkg.sv
hw/dbg_key_pulse.sv
hw/dbg_step_ctrl.sv
hw/dbg_retire_capture.sv
hw/dbg_seg7_display.sv
hw/dbg_sys_top.sv
test/tb_clk_gen.sv
test/dbg_sys_top_chk.sv
test/tb_dbg_sys_top.sv
